/* verilog/rv_pkg.sv */
package rv_pkg;

    localparam int IMEM_DEPTH = 256;              // Instruction words
    localparam int IMEM_AW    = 8;                // Word index from PC bits 9:2
    localparam int DMEM_DEPTH = 64;               // Data words
    localparam int DMEM_AW    = 6;                // Word index from address bits 7:2

    // Major opcodes of the supported subset
    typedef enum logic [ 6 : 0 ] {
        OP_R      = 7'b0110011,                   // Register-register ALU
        OP_I      = 7'b0010011,                   // Register-immediate ALU
        OP_LOAD   = 7'b0000011,                   // lw
        OP_STORE  = 7'b0100011,                   // sw
        OP_BRANCH = 7'b1100011,                   // beq, bne
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [ 1 : 0 ] {
        ALUOP_ADD    = 2'b00,                     // Address calc for lw/sw
        ALUOP_BRANCH = 2'b01,                     // Compare by subtraction
        ALUOP_FUNCT  = 2'b10                      // Decode funct3/funct7
    } alu_op_e;

    typedef enum logic [ 3 : 0 ] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,                           // Signed compare
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_ctrl_e;

    typedef enum logic [ 2 : 0 ] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3
    } imm_src_e;

endpackage

/* verilog/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if import rv_pkg::*; ();

    logic             pc_src;                     // Take branch or jal target
    logic             jalr_pc_src;                // Target is ALU result, bit 0 cleared
    logic             result_src;                 // Write back memory data
    logic             jstore;                     // Write back pc+4
    logic             mem_write;                  // Store enable, not yet gated by run
    logic             alu_src;                    // ALU B from immediate
    logic             reg_write;                  // Register write, not yet gated by run
    alu_ctrl_e        alu_ctrl;
    logic [ 31 : 0 ]  imm_ext;                    // Sign-extended immediate
    logic [ 4 : 0 ]   rs1;
    logic [ 4 : 0 ]   rs2;
    logic [ 4 : 0 ]   rd;

    modport ctrl (
        output pc_src, jalr_pc_src, result_src, jstore, mem_write, alu_src,
               reg_write, alu_ctrl, imm_ext, rs1, rs2, rd
    );

    modport dp (
        input  pc_src, jalr_pc_src, result_src, jstore, mem_write, alu_src,
               reg_write, alu_ctrl, imm_ext, rs1, rs2, rd
    );

endinterface

/* verilog/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem import rv_pkg::*; (
    input  logic                      clk,
    input  logic                      run_i,     // Core running
    input  logic                      we_i,      // Program load strobe
    input  logic [ IMEM_AW - 1 : 0 ]  waddr_i,   // Word index
    input  logic [ 31 : 0 ]           wdata_i,
    input  logic [ 31 : 0 ]           addr_i,    // Byte address from PC
    output logic [ 31 : 0 ]           rd_o
);

    logic [ 31 : 0 ] mem [ IMEM_DEPTH ];         // Program store, no reset

    always_ff @( posedge clk ) begin
        if ( we_i ) begin
            mem[ waddr_i ] <= wdata_i;
        end
    end

    // Upper PC bits ignored, fetch wraps in the array
    assign rd_o = mem[ addr_i[ IMEM_AW + 1 : 2 ] ];

    // Program may only be loaded while the core is halted
    a_no_load_while_running : assert property (
        @( posedge clk ) we_i |-> !run_i
    ) else $error( "instr_mem: program write while core is running" );

endmodule

/* verilog/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder import rv_pkg::*; (
    input  logic             eq_i,           // Operands equal
    input  logic [ 6 : 0 ]   op_i,
    input  logic [ 2 : 0 ]   funct3_i,       // Branch kind
    output logic             pc_src_o,       // Redirect to pc+imm
    output logic             result_src_o,   // Load data to rd
    output logic             mem_write_o,
    output logic             alu_src_o,      // Immediate as ALU B
    output logic             reg_write_o,
    output logic             jalr_pc_src_o,  // Redirect to rs1+imm
    output logic             jstore_o,       // Link value pc+4 to rd
    output imm_src_e         imm_src_o,
    output alu_op_e          alu_op_o
);

    logic branch;                            // Conditional branch opcode
    logic jump;                              // jal opcode
    logic take;                              // Branch condition met

    always_comb begin
        branch        = 1'b0;                // Defaults give a no-op
        jump          = 1'b0;
        result_src_o  = 1'b0;
        mem_write_o   = 1'b0;
        alu_src_o     = 1'b0;
        reg_write_o   = 1'b0;
        jalr_pc_src_o = 1'b0;
        jstore_o      = 1'b0;
        imm_src_o     = IMM_I;
        alu_op_o      = ALUOP_ADD;
        case ( op_i )
            OP_R: begin
                reg_write_o = 1'b1;
                alu_op_o    = ALUOP_FUNCT;
            end
            OP_I: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = ALUOP_FUNCT;
            end
            OP_LOAD: begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;         // rs1 + offset
                result_src_o = 1'b1;
            end
            OP_STORE: begin
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = IMM_S;
            end
            OP_BRANCH: begin
                branch    = 1'b1;
                imm_src_o = IMM_B;
                alu_op_o  = ALUOP_BRANCH;    // rs1 - rs2 feeds eq_i
            end
            OP_JAL: begin
                jump        = 1'b1;
                reg_write_o = 1'b1;
                jstore_o    = 1'b1;
                imm_src_o   = IMM_J;
            end
            OP_JALR: begin
                reg_write_o   = 1'b1;
                jstore_o      = 1'b1;
                alu_src_o     = 1'b1;        // Target = rs1 + imm
                jalr_pc_src_o = 1'b1;
            end
            default: ;                       // Unknown opcode, nothing written
        endcase
    end

    always_comb begin
        case ( funct3_i )
            3'b000:  take = eq_i;            // beq
            3'b001:  take = ~eq_i;           // bne
            default: take = 1'b0;
        endcase
    end

    assign pc_src_o = jump | ( branch & take );

endmodule

/* verilog/alu_decoder.sv */
`timescale 1ns/1ps

module alu_decoder import rv_pkg::*; (
    input  logic [ 2 : 0 ]  funct3_i,
    input  logic            funct7_i,       // Instruction bit 30
    input  logic            op5_i,          // High for R-type
    input  alu_op_e         alu_op_i,
    output alu_ctrl_e       alu_control_o
);

    always_comb begin
        case ( alu_op_i )
            ALUOP_ADD:    alu_control_o = ALU_ADD;     // lw/sw address
            ALUOP_BRANCH: alu_control_o = ALU_SUB;     // Zero flag means equal
            ALUOP_FUNCT: begin
                case ( funct3_i )
                    // addi with imm bit 30 set must stay add
                    3'b000:  alu_control_o = ( op5_i & funct7_i ) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_control_o = ALU_SLL;
                    3'b010:  alu_control_o = ALU_SLT;
                    3'b100:  alu_control_o = ALU_XOR;
                    3'b101:  alu_control_o = ALU_SRL;
                    3'b110:  alu_control_o = ALU_OR;
                    3'b111:  alu_control_o = ALU_AND;
                    default: alu_control_o = ALU_ADD;  // sltu not supported
                endcase
            end
            default:      alu_control_o = ALU_ADD;
        endcase
    end

endmodule

/* verilog/sign_extend.sv */
`timescale 1ns/1ps

module sign_extend import rv_pkg::*; (
    input  logic [ 31 : 7 ]  instr31_7_i,    // Opcode bits not needed
    input  imm_src_e         imm_src_i,
    output logic [ 31 : 0 ]  imm_ext_o
);

    logic sign;                              // Always instruction bit 31

    assign sign = instr31_7_i[ 31 ];

    always_comb begin
        case ( imm_src_i )
            IMM_I: imm_ext_o = { { 20{ sign } }, instr31_7_i[ 31 : 20 ] };
            IMM_S: imm_ext_o = { { 20{ sign } }, instr31_7_i[ 31 : 25 ],
                                 instr31_7_i[ 11 : 7 ] };
            // Branch offset in halfwords
            IMM_B: imm_ext_o = { { 20{ sign } }, instr31_7_i[ 7 ],
                                 instr31_7_i[ 30 : 25 ], instr31_7_i[ 11 : 8 ], 1'b0 };
            IMM_J: imm_ext_o = { { 12{ sign } }, instr31_7_i[ 19 : 12 ],
                                 instr31_7_i[ 20 ], instr31_7_i[ 30 : 21 ], 1'b0 };
            default: imm_ext_o = '0;         // Unused encodings
        endcase
    end

endmodule

/* verilog/control_top.sv */
`timescale 1ns/1ps

module control_top import rv_pkg::*; (
    input  logic                      clk,
    input  logic                      run_i,        // Core running, used for load check
    input  logic [ 31 : 0 ]           pc_i,         // Current PC
    input  logic                      eq_i,         // ALU zero flag
    ctrl_if.ctrl                      ctrl,         // Decoded controls to datapath
    input  logic                      prog_we_i,    // Program load strobe
    input  logic [ IMEM_AW - 1 : 0 ]  prog_addr_i,  // Program word index
    input  logic [ 31 : 0 ]           prog_data_i
);

    logic [ 31 : 0 ]  instr;                        // Fetched word
    opcode_e          op;
    logic [ 2 : 0 ]   funct3;
    logic             funct7;                       // Only bit 30 matters here
    alu_op_e          alu_op;
    imm_src_e         imm_src;

    assign op       = opcode_e'( instr[ 6 : 0 ] );
    assign funct3   = instr[ 14 : 12 ];
    assign funct7   = instr[ 30 ];
    assign ctrl.rs1 = instr[ 19 : 15 ];
    assign ctrl.rs2 = instr[ 24 : 20 ];
    assign ctrl.rd  = instr[ 11 : 7 ];

    instr_mem instr_mem_i (
        .clk     ( clk ),
        .run_i   ( run_i ),
        .we_i    ( prog_we_i ),
        .waddr_i ( prog_addr_i ),
        .wdata_i ( prog_data_i ),
        .addr_i  ( pc_i ),
        .rd_o    ( instr )
    );

    main_decoder main_decoder_i (
        .eq_i          ( eq_i ),
        .op_i          ( op ),
        .funct3_i      ( funct3 ),
        .pc_src_o      ( ctrl.pc_src ),
        .result_src_o  ( ctrl.result_src ),
        .mem_write_o   ( ctrl.mem_write ),
        .alu_src_o     ( ctrl.alu_src ),
        .reg_write_o   ( ctrl.reg_write ),
        .jalr_pc_src_o ( ctrl.jalr_pc_src ),
        .jstore_o      ( ctrl.jstore ),
        .imm_src_o     ( imm_src ),
        .alu_op_o      ( alu_op )
    );

    alu_decoder alu_decoder_i (
        .funct3_i      ( funct3 ),
        .funct7_i      ( funct7 ),
        .op5_i         ( op[ 5 ] ),                 // Set for R-type, clear for I-type
        .alu_op_i      ( alu_op ),
        .alu_control_o ( ctrl.alu_ctrl )
    );

    sign_extend sign_extend_i (
        .instr31_7_i ( instr[ 31 : 7 ] ),
        .imm_src_i   ( imm_src ),
        .imm_ext_o   ( ctrl.imm_ext )
    );

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic [ 4 : 0 ]   ra1_i,          // rs1 index
    input  logic [ 4 : 0 ]   ra2_i,          // rs2 index
    input  logic [ 4 : 0 ]   wa_i,           // rd index
    input  logic             we_i,           // Already gated by run
    input  logic [ 31 : 0 ]  wd_i,
    output logic [ 31 : 0 ]  rd1_o,
    output logic [ 31 : 0 ]  rd2_o
);

    logic [ 31 : 0 ] regs [ 32 ];

    always_ff @( posedge clk or negedge rst_n_i ) begin
        if ( !rst_n_i ) begin
            for ( int i = 0; i < 32; i++ ) begin
                regs[ i ] <= '0;
            end
        end else if ( we_i && ( wa_i != 5'd0 ) ) begin   // x0 writes dropped
            regs[ wa_i ] <= wd_i;
        end
    end

    // x0 hardwired to zero on both ports
    assign rd1_o = ( ra1_i == 5'd0 ) ? '0 : regs[ ra1_i ];
    assign rd2_o = ( ra2_i == 5'd0 ) ? '0 : regs[ ra2_i ];

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  logic [ 31 : 0 ]  a_i,
    input  logic [ 31 : 0 ]  b_i,
    input  alu_ctrl_e        ctrl_i,
    output logic [ 31 : 0 ]  y_o,
    output logic             zero_o      // Result is zero
);

    always_comb begin
        case ( ctrl_i )
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            ALU_SLT: y_o = { 31'd0, $signed( a_i ) < $signed( b_i ) };
            ALU_SLL: y_o = a_i << b_i[ 4 : 0 ];     // Shift amount 0..31
            ALU_SRL: y_o = a_i >> b_i[ 4 : 0 ];     // Logical, zero fill
            default: y_o = '0;
        endcase
    end

    assign zero_o = ( y_o == 32'd0 );

endmodule

/* verilog/data_mem.sv */
`timescale 1ns/1ps

module data_mem import rv_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             we_i,       // Store, gated by run
    input  logic [ 31 : 0 ]  addr_i,     // Byte address
    input  logic [ 31 : 0 ]  wd_i,
    output logic [ 31 : 0 ]  rd_o
);

    logic [ 31 : 0 ]          mem [ DMEM_DEPTH ];
    logic [ DMEM_AW - 1 : 0 ] idx;       // Word index, upper bits wrap

    assign idx = addr_i[ DMEM_AW + 1 : 2 ];

    always_ff @( posedge clk or negedge rst_n_i ) begin
        if ( !rst_n_i ) begin
            for ( int i = 0; i < DMEM_DEPTH; i++ ) begin
                mem[ i ] <= '0;
            end
        end else if ( we_i ) begin
            mem[ idx ] <= wd_i;
        end
    end

    assign rd_o = mem[ idx ];

    // Only whole-word stores, address comes from the ALU
    a_store_aligned : assert property (
        @( posedge clk ) disable iff ( !rst_n_i ) we_i |-> ( addr_i[ 1 : 0 ] == 2'b00 )
    ) else $error( "data_mem: misaligned store to %h", addr_i );

endmodule

/* verilog/riscv_top.sv */
`timescale 1ns/1ps

module riscv_top import rv_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      run_i,         // Retire one instruction per edge
    input  logic                      prog_we_i,     // Program load, only while halted
    input  logic [ IMEM_AW - 1 : 0 ]  prog_addr_i,
    input  logic [ 31 : 0 ]           prog_data_i,
    output logic [ 31 : 0 ]           pc_o,
    output logic                      wb_en_o,       // Register write this cycle
    output logic [ 4 : 0 ]            wb_addr_o,
    output logic [ 31 : 0 ]           wb_data_o,
    output logic                      dmem_we_o,     // Store this cycle
    output logic [ 31 : 0 ]           dmem_addr_o,
    output logic [ 31 : 0 ]           dmem_wdata_o
);

    ctrl_if           ctrl_bus ();                   // Decoded controls

    logic [ 31 : 0 ]  pc;
    logic [ 31 : 0 ]  pc_plus4;
    logic [ 31 : 0 ]  pc_target;                     // Branch and jal target
    logic [ 31 : 0 ]  pc_next;
    logic [ 31 : 0 ]  rd1;
    logic [ 31 : 0 ]  rd2;
    logic [ 31 : 0 ]  alu_b;
    logic [ 31 : 0 ]  alu_y;
    logic             alu_zero;
    logic [ 31 : 0 ]  mem_rd;
    logic [ 31 : 0 ]  result;                        // Write-back value
    logic             reg_we;
    logic             mem_we;

    // PC only advances while running
    always_ff @( posedge clk or negedge rst_n_i ) begin
        if ( !rst_n_i ) begin
            pc <= '0;
        end else if ( run_i ) begin
            pc <= pc_next;
        end
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + ctrl_bus.imm_ext;

    always_comb begin
        if ( ctrl_bus.jalr_pc_src ) begin
            pc_next = { alu_y[ 31 : 1 ], 1'b0 };     // jalr clears bit 0
        end else if ( ctrl_bus.pc_src ) begin
            pc_next = pc_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    assign alu_b  = ctrl_bus.alu_src ? ctrl_bus.imm_ext : rd2;
    assign result = ctrl_bus.jstore     ? pc_plus4 :  // Link address
                    ctrl_bus.result_src ? mem_rd   : alu_y;

    assign reg_we = run_i & ctrl_bus.reg_write;     // No side effects while halted
    assign mem_we = run_i & ctrl_bus.mem_write;

    control_top control_top_i (
        .clk         ( clk ),
        .run_i       ( run_i ),
        .pc_i        ( pc ),
        .eq_i        ( alu_zero ),
        .ctrl        ( ctrl_bus ),
        .prog_we_i   ( prog_we_i ),
        .prog_addr_i ( prog_addr_i ),
        .prog_data_i ( prog_data_i )
    );

    reg_file reg_file_i (
        .clk     ( clk ),
        .rst_n_i ( rst_n_i ),
        .ra1_i   ( ctrl_bus.rs1 ),
        .ra2_i   ( ctrl_bus.rs2 ),
        .wa_i    ( ctrl_bus.rd ),
        .we_i    ( reg_we ),
        .wd_i    ( result ),
        .rd1_o   ( rd1 ),
        .rd2_o   ( rd2 )
    );

    alu alu_i (
        .a_i    ( rd1 ),
        .b_i    ( alu_b ),
        .ctrl_i ( ctrl_bus.alu_ctrl ),
        .y_o    ( alu_y ),
        .zero_o ( alu_zero )
    );

    data_mem data_mem_i (
        .clk     ( clk ),
        .rst_n_i ( rst_n_i ),
        .we_i    ( mem_we ),
        .addr_i  ( alu_y ),
        .wd_i    ( rd2 ),
        .rd_o    ( mem_rd )
    );

    assign pc_o         = pc;
    assign wb_en_o      = reg_we;
    assign wb_addr_o    = ctrl_bus.rd;
    assign wb_data_o    = result;
    assign dmem_we_o    = mem_we;
    assign dmem_addr_o  = alu_y;
    assign dmem_wdata_o = rd2;                       // Store data is rs2

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 4;        // 8 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat ( RESET_CYCLES ) @( posedge clk_o );
        @( negedge clk_o );                 // Release away from the active edge
        rst_n_o = 1'b1;
    end

endmodule

/* testbench/riscv_tb.sv */
`timescale 1ns/1ps

module riscv_tb import rv_pkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int ALU_RUN        = 400;
    localparam int MEM_RUN        = 300;
    localparam int CF_RUN         = 300;
    localparam int X0_RUN         = 200;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * ( IMEM_DEPTH + 1 ) + ALU_RUN
                                    + MEM_RUN + CF_RUN + X0_RUN + 100;

    logic            clk;
    logic            rst_n;
    logic            run;
    logic            prog_we;
    logic [ 7 : 0 ]  prog_addr;
    logic [ 31 : 0 ] prog_data;
    logic [ 31 : 0 ] pc;
    logic            wb_en;
    logic [ 4 : 0 ]  wb_addr;
    logic [ 31 : 0 ] wb_data;
    logic            dmem_we;
    logic [ 31 : 0 ] dmem_addr;
    logic [ 31 : 0 ] dmem_wdata;

    integer          seed;
    int              errors;
    int              checks;
    int              test_cycles;               // Steps in the running test
    int              test_err_base;             // Error count at test start
    int              cycle_count;               // Timeout counter
    logic [ 31 : 0 ] prog   [ IMEM_DEPTH ];     // Program image, also the model's fetch
    logic [ 31 : 0 ] m_regs [ 32 ];             // Model registers
    logic [ 31 : 0 ] m_dmem [ DMEM_DEPTH ];     // Model data memory
    logic [ 31 : 0 ] m_pc;

    tb_clock tb_clock_i ( .clk_o ( clk ), .rst_n_o ( rst_n ) );

    riscv_top riscv_top_i (
        .clk          ( clk ),
        .rst_n_i      ( rst_n ),
        .run_i        ( run ),
        .prog_we_i    ( prog_we ),
        .prog_addr_i  ( prog_addr ),
        .prog_data_i  ( prog_data ),
        .pc_o         ( pc ),
        .wb_en_o      ( wb_en ),
        .wb_addr_o    ( wb_addr ),
        .wb_data_o    ( wb_data ),
        .dmem_we_o    ( dmem_we ),
        .dmem_addr_o  ( dmem_addr ),
        .dmem_wdata_o ( dmem_wdata )
    );

    function automatic int unsigned rand_below( input int unsigned n );
        return $unsigned( $random( seed ) ) % n;
    endfunction

    function automatic logic [ 31 : 0 ] enc_i( input logic [ 11 : 0 ] imm, input logic [ 4 : 0 ] rs1,
                                               input logic [ 2 : 0 ] f3, input logic [ 4 : 0 ] rd,
                                               input logic [ 6 : 0 ] op );
        return { imm, rs1, f3, rd, op };
    endfunction

    function automatic logic [ 31 : 0 ] enc_s( input logic [ 11 : 0 ] imm, input logic [ 4 : 0 ] rs2,
                                               input logic [ 4 : 0 ] rs1 );
        return { imm[ 11 : 5 ], rs2, rs1, 3'b010, imm[ 4 : 0 ], OP_STORE };   // sw
    endfunction

    function automatic logic [ 31 : 0 ] enc_b( input logic [ 12 : 0 ] imm, input logic [ 4 : 0 ] rs2,
                                               input logic [ 4 : 0 ] rs1, input logic [ 2 : 0 ] f3 );
        return { imm[ 12 ], imm[ 10 : 5 ], rs2, rs1, f3, imm[ 4 : 1 ], imm[ 11 ], OP_BRANCH };
    endfunction

    function automatic logic [ 31 : 0 ] enc_j( input logic [ 20 : 0 ] imm, input logic [ 4 : 0 ] rd );
        return { imm[ 20 ], imm[ 10 : 1 ], imm[ 11 ], imm[ 19 : 12 ], rd, OP_JAL };
    endfunction

    // Random R-type or I-type ALU instruction writing rd
    function automatic logic [ 31 : 0 ] gen_alu( input logic [ 4 : 0 ] rd );
        logic [ 2 : 0 ] f3;
        logic [ 6 : 0 ] f7;
        if ( rand_below( 2 ) == 0 ) begin
            f3 = 3'( rand_below( 8 ) );
            if ( f3 == 3'b011 ) f3 = 3'b000;     // No sltu
            f7 = ( f3 == 3'b000 && rand_below( 2 ) == 1 ) ? 7'h20 : 7'h00;   // sub or add
            return { f7, 5'( rand_below( 32 ) ), 5'( rand_below( 32 ) ), f3, rd, OP_R };
        end
        case ( rand_below( 5 ) )
            0:       f3 = 3'b000;                // addi
            1:       f3 = 3'b010;                // slti
            2:       f3 = 3'b100;                // xori
            3:       f3 = 3'b110;                // ori
            default: f3 = 3'b111;                // andi
        endcase
        return enc_i( 12'( rand_below( 4096 ) ), 5'( rand_below( 32 ) ), f3, rd, OP_I );
    endfunction

    // Branches, jumps and small addi to make equal registers likely
    function automatic logic [ 31 : 0 ] gen_flow();
        int unsigned r;
        int          off;
        r = rand_below( 10 );
        if ( r < 3 ) begin
            return enc_i( 12'( rand_below( 4 ) ), 5'( rand_below( 4 ) ), 3'b000,
                          5'( 1 + rand_below( 3 ) ), OP_I );
        end else if ( r < 6 ) begin
            off = ( int'( rand_below( 64 ) ) - 32 ) * 4;
            if ( off == 0 ) off = 4;             // Avoid a self loop
            return enc_b( 13'( off ), 5'( rand_below( 4 ) ), 5'( rand_below( 4 ) ),
                          3'( rand_below( 2 ) ) );
        end else if ( r < 8 ) begin
            off = ( int'( rand_below( 256 ) ) - 128 ) * 4;
            if ( off == 0 ) off = 4;
            return enc_j( 21'( off ), 5'( rand_below( 32 ) ) );
        end
        return enc_i( 12'( rand_below( 64 ) * 4 ), 5'( rand_below( 4 ) ), 3'b000,
                      5'( rand_below( 32 ) ), OP_JALR );
    endfunction

    task automatic fill_program( input int kind );
        for ( int i = 0; i < IMEM_DEPTH; i++ ) begin
            case ( kind )
                0: prog[ i ] = gen_alu( 5'( rand_below( 32 ) ) );
                1: begin
                    if ( rand_below( 2 ) == 0 )  // Word offsets from x0 over all of dmem
                        prog[ i ] = enc_s( 12'( rand_below( 64 ) * 4 ), 5'( rand_below( 32 ) ), 5'd0 );
                    else
                        prog[ i ] = enc_i( 12'( rand_below( 64 ) * 4 ), 5'd0, 3'b010,
                                           5'( rand_below( 32 ) ), OP_LOAD );
                end
                2: prog[ i ] = gen_flow();
                default: begin
                    if ( i % 2 == 0 ) begin
                        prog[ i ] = gen_alu( 5'd0 );           // Write to x0
                    end else begin
                        case ( rand_below( 3 ) )           // Read x0 back
                            0: prog[ i ] = { 7'h00, 5'd0, 5'd0, 3'b110, 5'( 1 + rand_below( 31 ) ), OP_R };
                            1: prog[ i ] = enc_i( 12'( rand_below( 4096 ) ), 5'd0, 3'b000,
                                                  5'( 1 + rand_below( 31 ) ), OP_I );
                            default: prog[ i ] = enc_s( 12'( rand_below( 64 ) * 4 ), 5'd0, 5'd0 );
                        endcase
                    end
                end
            endcase
        end
    endtask

    task automatic check_value( input string name, input logic [ 31 : 0 ] expected,
                                input logic [ 31 : 0 ] actual );
        checks++;
        if ( actual !== expected ) begin
            errors++;
            $display( "mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual );
        end
    endtask

    // RV32I rules for the eight ALU functions
    function automatic logic [ 31 : 0 ] alu_model( input logic [ 2 : 0 ] f3, input logic sub,
                                                   input logic [ 31 : 0 ] a, input logic [ 31 : 0 ] b );
        case ( f3 )
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[ 4 : 0 ];
            3'b010:  return ( $signed( a ) < $signed( b ) ) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[ 4 : 0 ];
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // Expected outputs for the instruction at m_pc, then retire it in the model
    task automatic predict_and_check( input logic running );
        logic [ 31 : 0 ] instr;
        logic [ 31 : 0 ] a;
        logic [ 31 : 0 ] b;
        logic [ 31 : 0 ] imm_i;
        logic [ 31 : 0 ] imm_s;
        logic [ 31 : 0 ] imm_b;
        logic [ 31 : 0 ] imm_j;
        logic [ 31 : 0 ] next_pc;
        logic [ 31 : 0 ] wb_val;
        logic [ 31 : 0 ] addr;
        logic [ 6 : 0 ]  op;
        logic [ 2 : 0 ]  f3;
        logic [ 4 : 0 ]  rd;
        logic            wr;
        logic            st;
        logic            ld;
        instr   = prog[ m_pc[ 9 : 2 ] ];         // Fetch wraps in 256 words
        op      = instr[ 6 : 0 ];
        f3      = instr[ 14 : 12 ];
        rd      = instr[ 11 : 7 ];
        a       = m_regs[ instr[ 19 : 15 ] ];
        b       = m_regs[ instr[ 24 : 20 ] ];
        imm_i   = { { 20{ instr[ 31 ] } }, instr[ 31 : 20 ] };
        imm_s   = { { 20{ instr[ 31 ] } }, instr[ 31 : 25 ], instr[ 11 : 7 ] };
        imm_b   = { { 19{ instr[ 31 ] } }, instr[ 31 ], instr[ 7 ], instr[ 30 : 25 ],
                    instr[ 11 : 8 ], 1'b0 };
        imm_j   = { { 11{ instr[ 31 ] } }, instr[ 31 ], instr[ 19 : 12 ], instr[ 20 ],
                    instr[ 30 : 21 ], 1'b0 };
        next_pc = m_pc + 32'd4;
        wr      = 1'b0;
        st      = 1'b0;
        ld      = 1'b0;
        wb_val  = '0;
        addr    = '0;
        case ( op )
            OP_R: begin
                wr     = 1'b1;
                wb_val = alu_model( f3, instr[ 30 ], a, b );
            end
            OP_I: begin
                wr     = 1'b1;
                wb_val = alu_model( f3, 1'b0, a, imm_i );   // No subi
            end
            OP_LOAD: begin
                wr     = 1'b1;
                ld     = 1'b1;
                addr   = a + imm_i;
                wb_val = m_dmem[ addr[ 7 : 2 ] ];
            end
            OP_STORE: begin
                st   = 1'b1;
                addr = a + imm_s;
            end
            OP_BRANCH: begin
                if ( ( f3 == 3'b000 && a == b ) || ( f3 == 3'b001 && a != b ) )
                    next_pc = m_pc + imm_b;
            end
            OP_JAL: begin
                wr      = 1'b1;
                wb_val  = m_pc + 32'd4;
                next_pc = m_pc + imm_j;
            end
            OP_JALR: begin
                wr      = 1'b1;
                wb_val  = m_pc + 32'd4;
                next_pc = ( a + imm_i ) & ~32'd1;
            end
            default: ;
        endcase
        if ( !running ) begin                    // Halted core has no side effects
            wr = 1'b0;
            st = 1'b0;
            ld = 1'b0;
        end
        check_value( "pc_o", m_pc, pc );
        check_value( "wb_en_o", 32'( wr ), 32'( wb_en ) );
        check_value( "dmem_we_o", 32'( st ), 32'( dmem_we ) );
        if ( wr ) begin
            check_value( "wb_addr_o", 32'( rd ), 32'( wb_addr ) );
            check_value( "wb_data_o", wb_val, wb_data );
        end
        if ( st || ld ) check_value( "dmem_addr_o", addr, dmem_addr );
        if ( st ) check_value( "dmem_wdata_o", b, dmem_wdata );
        if ( running ) begin
            if ( wr && rd != 5'd0 ) m_regs[ rd ] = wb_val;
            if ( st ) m_dmem[ addr[ 7 : 2 ] ] = b;
            m_pc = next_pc;
        end
    endtask

    // One clock: drive on the falling edge, check mid low phase
    task automatic run_cycle( input logic running );
        @( negedge clk );
        run     = running;
        prog_we = 1'b0;
        #2;
        predict_and_check( running );
        test_cycles++;
    endtask

    task automatic load_program();
        for ( int i = 0; i < IMEM_DEPTH; i++ ) begin
            @( negedge clk );
            run       = 1'b0;
            prog_we   = 1'b1;
            prog_addr = 8'( i );
            prog_data = prog[ i ];
            #2;
            predict_and_check( 1'b0 );           // PC frozen, no writes
            test_cycles++;
        end
    endtask

    task automatic end_test( input int num, input string name );
        $display( "test %0d %s: %0d cycles, %0d errors", num, name, test_cycles,
                  errors - test_err_base );
        test_cycles   = 0;
        test_err_base = errors;
    endtask

    always @( posedge clk ) begin
        cycle_count++;
        if ( cycle_count >= TIMEOUT_CYCLES ) begin
            $display( "timeout: run still going after %0d cycles", cycle_count );
            $display( "ERRORS FOUND" );
            $finish;
        end
    end

    initial begin
        run           = 1'b0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        seed          = 32'h9541ca77;
        errors        = 0;
        checks        = 0;
        test_cycles   = 0;
        test_err_base = 0;
        cycle_count   = 0;
        m_pc          = '0;
        for ( int i = 0; i < 32; i++ ) m_regs[ i ] = '0;
        for ( int i = 0; i < DMEM_DEPTH; i++ ) m_dmem[ i ] = '0;
        @( posedge rst_n );

        fill_program( 0 );
        load_program();
        end_test( 1, "reset and program load" );
        repeat ( ALU_RUN ) run_cycle( 1'b1 );
        end_test( 2, "random ALU" );

        fill_program( 1 );
        load_program();
        repeat ( MEM_RUN ) run_cycle( 1'b1 );
        end_test( 3, "load and store" );

        fill_program( 2 );
        load_program();
        repeat ( CF_RUN ) run_cycle( 1'b1 );
        end_test( 4, "branches and jumps" );

        fill_program( 3 );
        load_program();
        for ( int c = 0; c < X0_RUN; c++ ) begin    // Random stalls plus one long pause
            run_cycle( !( rand_below( 4 ) == 0 || ( c >= 100 && c < 110 ) ) );
        end
        end_test( 5, "x0 and run gating" );

        $display( "checks %0d, errors %0d", checks, errors );
        if ( errors == 0 ) begin
            $display( "NO ERRORS" );
        end else begin
            $display( "ERRORS FOUND" );
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/rv_pkg.sv
verilog/ctrl_if.sv
verilog/instr_mem.sv
verilog/main_decoder.sv
verilog/alu_decoder.sv
verilog/sign_extend.sv
verilog/control_top.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/riscv_top.sv
testbench/tb_clock.sv
testbench/riscv_tb.sv
